// File: cpu_defs.svh
// Core sizing macros: word width, instruction memory depth, PC width, register count
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Datapath and instruction word width
`define CPU_XLEN 16

// Instruction memory words
`define CPU_IMEM_DEPTH 256

// PC bits, log2 of the memory depth
`define CPU_PC_W 8

// General registers, indexed by a 4-bit field
`define CPU_NREGS 16

`endif

// File: cpu_host_regs.sv
// AXI4-Lite slave: control, status, PC, retired count, register read-back, imem load window
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module cpu_host_regs (
	input  wire logic                             clk,
	input  wire logic                             rst_n,
	input  wire logic [hostmap_pkg::ADDR_W-1:0]   awaddr,
	input  wire logic                             awvalid,
	output logic                                  awready,
	input  wire logic [hostmap_pkg::DATA_W-1:0]   wdata,
	input  wire logic [hostmap_pkg::DATA_W/8-1:0] wstrb,
	input  wire logic                             wvalid,
	output logic                                  wready,
	output logic [1:0]                            bresp,
	output logic                                  bvalid,
	input  wire logic                             bready,
	input  wire logic [hostmap_pkg::ADDR_W-1:0]   araddr,
	input  wire logic                             arvalid,
	output logic                                  arready,
	output logic [hostmap_pkg::DATA_W-1:0]        rdata,
	output logic [1:0]                            rresp,
	output logic                                  rvalid,
	input  wire logic                             rready,
	output logic                                  start,
	output logic                                  run,
	output logic                                  imem_we,
	output logic [`CPU_PC_W-1:0]                  imem_addr,
	output logic [`CPU_XLEN-1:0]                  imem_wdata,
	output logic [3:0]                            reg_rd_idx,
	input  wire logic [`CPU_PC_W-1:0]             pc,
	input  wire logic                             halted,
	input  wire logic [`CPU_XLEN-1:0]             retired,
	input  wire logic [`CPU_XLEN-1:0]             reg_rd_data
);

	localparam int REG_LSB  = $clog2(`CPU_NREGS) + 2;	// bits above the register window
	localparam int IMEM_LSB = `CPU_PC_W + 2;			// bits above the imem window

	logic                           running;	// set by start, dropped on halt
	logic                           wr_fire;
	logic                           wr_is_ctrl;
	logic                           wr_is_imem;
	logic                           rd_fire;
	logic                           rd_err;
	logic [hostmap_pkg::DATA_W-1:0] rd_word;

	// Write decode
	assign wr_is_ctrl = (awaddr == hostmap_pkg::CTRL_OFS);
	assign wr_is_imem = ((awaddr >> IMEM_LSB) == (hostmap_pkg::IMEM_BASE >> IMEM_LSB));

	// AW and W taken together, never with a response outstanding
	assign wr_fire = awvalid && wvalid && !bvalid;
	assign awready = wr_fire;
	assign wready  = wr_fire;

	assign start      = wr_fire && wr_is_ctrl && wstrb[0] && wdata[hostmap_pkg::CTRL_START_BIT];
	assign imem_we    = wr_fire && wr_is_imem && !run && (&wstrb[1:0]);	// partial word dropped
	assign imem_addr  = awaddr[IMEM_LSB-1:2];
	assign imem_wdata = wdata[`CPU_XLEN-1:0];

	// Fetch runs until the HALT retires
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			running <= 1'b0;
		else if (start)
			running <= 1'b1;
		else if (halted)
			running <= 1'b0;
	end
	assign run = running && !halted;	// drops in the halted cycle itself

	// B channel
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			bvalid <= 1'b0;
		else if (wr_fire)
			bvalid <= 1'b1;
		else if (bready)
			bvalid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (wr_fire) begin
			// Only CTRL and a stopped imem accept writes
			bresp <= (wr_is_ctrl || (wr_is_imem && !run)) ?
				hostmap_pkg::RESP_OKAY : hostmap_pkg::RESP_SLVERR;
		end
	end

	// Read decode
	assign reg_rd_idx = araddr[REG_LSB-1:2];	// register file read port, combinational

	always_comb begin
		rd_word = '0;
		rd_err  = 1'b0;
		if ((araddr >> REG_LSB) == (hostmap_pkg::REG_BASE >> REG_LSB)) begin
			rd_word[`CPU_XLEN-1:0] = reg_rd_data;
		end else begin
			case (araddr)
				hostmap_pkg::CTRL_OFS: rd_word = '0;	// start is a pulse
				hostmap_pkg::STATUS_OFS: begin
					rd_word[hostmap_pkg::STAT_HALTED_BIT]  = halted;
					rd_word[hostmap_pkg::STAT_RUNNING_BIT] = run;
				end
				hostmap_pkg::PC_OFS:      rd_word[`CPU_PC_W-1:0] = pc;
				hostmap_pkg::RETIRED_OFS: rd_word[`CPU_XLEN-1:0] = retired;
				default:                  rd_err = 1'b1;	// holes and the write-only imem
			endcase
		end
	end

	// R channel, one read in flight
	assign arready = !rvalid;
	assign rd_fire = arvalid && !rvalid;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rvalid <= 1'b0;
		else if (rd_fire)
			rvalid <= 1'b1;
		else if (rready)
			rvalid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (rd_fire) begin
			rdata <= rd_word;	// zero on error
			rresp <= rd_err ? hostmap_pkg::RESP_SLVERR : hostmap_pkg::RESP_OKAY;
		end
	end

	// Response held until the host takes it
	a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
		bvalid && !bready |=> bvalid);

endmodule

`default_nettype wire

// File: cpu_tb.sv
// Testbench for cpu_top with clock, reset, AXI4-Lite host tasks, LCG, ISA reference model, checks
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module cpu_tb;

	logic                                 clk;
	logic                                 rst_n;
	logic [hostmap_pkg::ADDR_W-1:0]       awaddr;
	logic                                 awvalid;
	logic                                 awready;
	logic [hostmap_pkg::DATA_W-1:0]       wdata;
	logic [hostmap_pkg::DATA_W/8-1:0]     wstrb;
	logic                                 wvalid;
	logic                                 wready;
	logic [1:0]                           bresp;
	logic                                 bvalid;
	logic                                 bready;
	logic [hostmap_pkg::ADDR_W-1:0]       araddr;
	logic                                 arvalid;
	logic                                 arready;
	logic [hostmap_pkg::DATA_W-1:0]       rdata;
	logic [1:0]                           rresp;
	logic                                 rvalid;
	logic                                 rready;

	logic [`CPU_XLEN-1:0] prog [`CPU_IMEM_DEPTH];		// host copy of imem
	logic [`CPU_XLEN-1:0] model_regs [`CPU_NREGS];
	logic [`CPU_XLEN-1:0] saved [`CPU_NREGS];			// registers before the jump test
	logic [31:0]          lcg_state;
	logic [31:0]          rnd;
	logic [31:0]          rd_data;
	logic [31:0]          act_ret2;
	logic [1:0]           resp;
	logic                 hung;		// some wait ran out
	int                   errors;
	int                   checks;
	int                   tests_run;
	int                   tests_failed;
	int                   errs_mark;
	int                   exp_ret2;
	int                   exp_ret3;
	int                   i;
	int                   wr_accepts;	// AW and W taken together
	int                   rd_accepts;	// AR taken
	string                name_q [$];	// pending compares
	logic [31:0]          exp_q [$];
	logic [31:0]          act_q [$];
	string                cmp_name;
	logic [31:0]          cmp_exp;
	logic [31:0]          cmp_act;

	cpu_top uut (
		.clk, .rst_n,
		.awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
		.bresp, .bvalid, .bready,
		.araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;	// 40 ns period

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [15:0] enc_r(isa_pkg::opcode_e op, logic [3:0] rd, logic [3:0] rs,
			logic [3:0] rt);
		isa_pkg::instr_u ir;
		ir.r_fmt.opcode = op;
		ir.r_fmt.rd     = rd;
		ir.r_fmt.rs     = rs;
		ir.r_fmt.rt     = rt;	// immediate for ADDI
		return ir;
	endfunction

	function automatic logic [15:0] enc_i(isa_pkg::opcode_e op, logic [3:0] rd, logic [7:0] imm);
		isa_pkg::instr_u ir;
		ir.i_fmt.opcode = op;
		ir.i_fmt.rd     = rd;
		ir.i_fmt.imm8   = imm;
		return ir;
	endfunction

	function automatic logic [15:0] enc_j(isa_pkg::opcode_e op, logic [11:0] target);
		isa_pkg::instr_u ir;
		ir.j_fmt.opcode   = op;
		ir.j_fmt.target12 = target;
		return ir;
	endfunction

	// Runs prog from PC 0 on model_regs and returns the retired count
	function automatic int model_run();
		isa_pkg::instr_u ir;
		logic [7:0]      pc_m;
		int              count;
		int              steps;
		pc_m  = 8'h00;
		count = 0;
		for (steps = 0; steps < 2000; steps++) begin
			ir   = prog[pc_m];
			pc_m = pc_m + 8'd1;		// wraps at depth
			case (ir.r_fmt.opcode)
				isa_pkg::OP_ADD:
					model_regs[ir.r_fmt.rd] = model_regs[ir.r_fmt.rs] + model_regs[ir.r_fmt.rt];
				isa_pkg::OP_SUB:
					model_regs[ir.r_fmt.rd] = model_regs[ir.r_fmt.rs] - model_regs[ir.r_fmt.rt];
				isa_pkg::OP_AND:
					model_regs[ir.r_fmt.rd] = model_regs[ir.r_fmt.rs] & model_regs[ir.r_fmt.rt];
				isa_pkg::OP_OR:
					model_regs[ir.r_fmt.rd] = model_regs[ir.r_fmt.rs] | model_regs[ir.r_fmt.rt];
				isa_pkg::OP_ADDI:
					model_regs[ir.r_fmt.rd] = model_regs[ir.r_fmt.rd] + {12'h000, ir.r_fmt.rt};
				isa_pkg::OP_LDI:  model_regs[ir.i_fmt.rd] = {8'h00, ir.i_fmt.imm8};
				isa_pkg::OP_JMP:  pc_m = ir.j_fmt.target12[7:0];	// modulo depth
				isa_pkg::OP_HALT: return count;		// HALT not counted
				default: ;							// NOP
			endcase
			count++;
		end
		return -1;	// never halted
	endfunction

	// Drains the compare queue on every rising edge
	always @(posedge clk) begin
		while (name_q.size() > 0) begin
			cmp_name = name_q.pop_front();
			cmp_exp  = exp_q.pop_front();
			cmp_act  = act_q.pop_front();
			checks++;
			assert (cmp_act == cmp_exp) else begin
				$display("[ERROR] %s: expected %h, actual %h", cmp_name, cmp_exp, cmp_act);
				errors++;
			end
		end
	end

	// Handshakes as the edge sees them
	always @(posedge clk) begin
		if (awvalid && awready && wvalid && wready)
			wr_accepts++;
		if (arvalid && arready)
			rd_accepts++;
	end

	task automatic expect_eq(string name, logic [31:0] exp, logic [31:0] act);
		name_q.push_back(name);
		exp_q.push_back(exp);
		act_q.push_back(act);
	endtask

	task automatic axi_write(input logic [11:0] addr, input logic [31:0] data,
			output logic [1:0] wr_resp);
		int n;
		int acc0;
		wr_resp = 2'b11;
		if (!hung) begin
			@(negedge clk);
			awaddr  = addr;
			wdata   = data;
			awvalid = 1'b1;
			wvalid  = 1'b1;
			bready  = 1'b1;
			acc0    = wr_accepts;
			n = 0;
			do begin
				@(negedge clk);
				n++;
			end while (!bvalid && n < 50);
			awvalid = 1'b0;
			wvalid  = 1'b0;
			if (bvalid) begin
				wr_resp = bresp;
				expect_eq("write accept count", 32'd1, 32'(wr_accepts - acc0));
			end else begin
				$display("Timeout: no write response for address %h", addr);
				hung = 1'b1;
			end
		end
	endtask

	task automatic axi_read(input logic [11:0] addr, output logic [31:0] data,
			output logic [1:0] rd_resp);
		int n;
		int acc0;
		data    = '0;
		rd_resp = 2'b11;
		if (!hung) begin
			@(negedge clk);
			araddr  = addr;
			arvalid = 1'b1;
			rready  = 1'b1;
			acc0    = rd_accepts;
			n = 0;
			do begin
				@(negedge clk);
				n++;
			end while (!rvalid && n < 50);
			arvalid = 1'b0;
			if (rvalid) begin
				data    = rdata;
				rd_resp = rresp;
				expect_eq("read accept count", 32'd1, 32'(rd_accepts - acc0));
			end else begin
				$display("Timeout: no read response for address %h", addr);
				hung = 1'b1;
			end
		end
	endtask

	task automatic load_word(int a, logic [15:0] w);
		logic [1:0] r;
		prog[8'(a)] = w;
		axi_write(12'(hostmap_pkg::IMEM_BASE + 4 * a), {16'h0000, w}, r);
		expect_eq("imem load resp", 32'(hostmap_pkg::RESP_OKAY), 32'(r));
	endtask

	// Polls STATUS until the halted bit
	task automatic wait_halted();
		logic [31:0] d;
		logic [1:0]  r;
		int          n;
		n = 0;
		do begin
			axi_read(hostmap_pkg::STATUS_OFS, d, r);
			n++;
		end while (!hung && !d[hostmap_pkg::STAT_HALTED_BIT] && n < 200);
		if (!hung && !d[hostmap_pkg::STAT_HALTED_BIT]) begin
			$display("Timeout: core never reported halted");
			hung = 1'b1;
		end
	endtask

	task automatic run_to_halt(output int exp_ret);
		logic [1:0] r;
		exp_ret = model_run();
		axi_write(hostmap_pkg::CTRL_OFS, 32'h1, r);
		expect_eq("start resp", 32'(hostmap_pkg::RESP_OKAY), 32'(r));
		wait_halted();
	endtask

	task automatic compare_regs(string tag);
		logic [31:0] d;
		logic [1:0]  r;
		for (int n = 0; n < `CPU_NREGS; n++) begin
			axi_read(12'(hostmap_pkg::REG_BASE + 4 * n), d, r);
			expect_eq($sformatf("%s r%0d", tag, n), {16'h0000, model_regs[n]}, d);
			expect_eq($sformatf("%s r%0d resp", tag, n), 32'(hostmap_pkg::RESP_OKAY), 32'(r));
		end
	endtask

	// Waits for pending compares and reports the test
	task automatic end_test(string name);
		int n;
		n = 0;
		while (name_q.size() > 0 && n < 10) begin
			@(negedge clk);
			n++;
		end
		if (name_q.size() > 0) begin
			$display("Timeout: compares for test %s never drained", name);
			hung = 1'b1;
		end
		tests_run++;
		if (errors != errs_mark || hung) begin
			tests_failed++;
			$display("Test %s: failed", name);
		end else
			$display("Test %s: ok", name);
		errs_mark = errors;
	endtask

	initial begin
		rst_n     = 1'b0;
		awaddr    = '0;
		awvalid   = 1'b0;
		wdata     = '0;
		wstrb     = 4'hF;
		wvalid    = 1'b0;
		bready    = 1'b0;
		araddr    = '0;
		arvalid   = 1'b0;
		rready    = 1'b0;
		hung      = 1'b0;
		errors    = 0;
		checks    = 0;
		tests_run = 0;
		tests_failed = 0;
		errs_mark = 0;
		wr_accepts = 0;
		rd_accepts = 0;
		lcg_state = 32'h0251d094;
		for (i = 0; i < `CPU_NREGS; i++)
			model_regs[i] = '0;
		repeat (5) @(negedge clk);
		rst_n = 1'b1;

		// Idle state after reset
		axi_read(hostmap_pkg::STATUS_OFS, rd_data, resp);
		expect_eq("reset status", 32'h0, rd_data);
		expect_eq("reset status resp", 32'(hostmap_pkg::RESP_OKAY), 32'(resp));
		axi_read(hostmap_pkg::PC_OFS, rd_data, resp);
		expect_eq("reset pc", 32'h0, rd_data);
		expect_eq("reset pc resp", 32'(hostmap_pkg::RESP_OKAY), 32'(resp));
		compare_regs("reset");
		end_test("reset");

		// 40 random ALU, ADDI, LDI words then HALT
		for (i = 0; i < 40; i++) begin
			rnd = lcg_next();
			load_word(i, {4'(rnd[31:16] % 16'd6), rnd[11:0]});	// opcodes 0..5
		end
		load_word(40, enc_j(isa_pkg::OP_HALT, 12'h000));
		run_to_halt(exp_ret2);
		compare_regs("random");
		axi_read(hostmap_pkg::RETIRED_OFS, act_ret2, resp);
		end_test("random program");

		// JMP over three LDIs
		for (i = 0; i < `CPU_NREGS; i++)
			saved[i] = model_regs[i];
		load_word(0, enc_i(isa_pkg::OP_LDI, 4'd1, 8'h11));
		load_word(1, enc_j(isa_pkg::OP_JMP, 12'h305));	// upper bits wrap to 5
		load_word(2, enc_i(isa_pkg::OP_LDI, 4'd2, 8'hA2));
		load_word(3, enc_i(isa_pkg::OP_LDI, 4'd3, 8'hA3));
		load_word(4, enc_i(isa_pkg::OP_LDI, 4'd4, 8'hA4));
		load_word(5, enc_i(isa_pkg::OP_LDI, 4'd5, 8'h55));
		load_word(6, enc_r(isa_pkg::OP_ADDI, 4'd5, 4'd0, 4'd3));
		load_word(7, enc_r(isa_pkg::OP_ADD, 4'd6, 4'd5, 4'd1));
		load_word(8, enc_j(isa_pkg::OP_HALT, 12'h000));
		run_to_halt(exp_ret3);
		compare_regs("jump");
		for (i = 2; i <= 4; i++) begin
			axi_read(12'(hostmap_pkg::REG_BASE + 4 * i), rd_data, resp);
			expect_eq($sformatf("jump skipped r%0d", i), {16'h0000, saved[i]}, rd_data);
		end
		end_test("jump");

		// Retired counts of both programs
		expect_eq("retired random", 32'(exp_ret2), act_ret2);
		axi_read(hostmap_pkg::RETIRED_OFS, rd_data, resp);
		expect_eq("retired jump", 32'(exp_ret3), rd_data);
		end_test("retired");

		// Host accesses while an endless loop runs
		load_word(0, enc_r(isa_pkg::OP_ADDI, 4'd7, 4'd0, 4'd1));
		load_word(1, enc_j(isa_pkg::OP_JMP, 12'h000));
		axi_write(hostmap_pkg::CTRL_OFS, 32'h1, resp);
		axi_read(hostmap_pkg::STATUS_OFS, rd_data, resp);
		expect_eq("busy status", 32'h2, rd_data);	// running only
		axi_write(12'(hostmap_pkg::IMEM_BASE + 4 * 10), 32'h0000_5123, resp);
		expect_eq("busy imem write resp", 32'(hostmap_pkg::RESP_SLVERR), 32'(resp));
		axi_read(12'h010, rd_data, resp);
		expect_eq("unmapped read resp", 32'(hostmap_pkg::RESP_SLVERR), 32'(resp));
		expect_eq("unmapped read data", 32'h0, rd_data);
		end_test("busy access");

		$display("Tests run %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0 && !hung) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: cpu_top.sv
// Core top: host AXI4-Lite block, fetch, IF/ID register and execute stage
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module cpu_top (
	input  wire logic                             clk,
	input  wire logic                             rst_n,
	input  wire logic [hostmap_pkg::ADDR_W-1:0]   awaddr,
	input  wire logic                             awvalid,
	output logic                                  awready,
	input  wire logic [hostmap_pkg::DATA_W-1:0]   wdata,
	input  wire logic [hostmap_pkg::DATA_W/8-1:0] wstrb,
	input  wire logic                             wvalid,
	output logic                                  wready,
	output logic [1:0]                            bresp,
	output logic                                  bvalid,
	input  wire logic                             bready,
	input  wire logic [hostmap_pkg::ADDR_W-1:0]   araddr,
	input  wire logic                             arvalid,
	output logic                                  arready,
	output logic [hostmap_pkg::DATA_W-1:0]        rdata,
	output logic [1:0]                            rresp,
	output logic                                  rvalid,
	input  wire logic                             rready
);

	logic                 start;
	logic                 run;
	logic                 imem_we;
	logic [`CPU_PC_W-1:0] imem_addr;
	logic [`CPU_XLEN-1:0] imem_wdata;
	logic [3:0]           reg_rd_idx;
	logic [`CPU_XLEN-1:0] reg_rd_data;
	logic [`CPU_PC_W-1:0] pc;
	logic                 halted;
	logic [`CPU_XLEN-1:0] retired;
	logic                 jump_en;
	logic [`CPU_PC_W-1:0] jump_target;
	logic                 flush;
	isa_pkg::instr_u      instr;
	logic                 instr_valid;
	logic                 id_valid;
	isa_pkg::opcode_e     id_opcode;
	logic [3:0]           id_rs;
	logic [3:0]           id_rt;
	logic [3:0]           id_rd;
	logic [3:0]           id_arith_imm;
	logic [7:0]           id_load_imm;
	logic [11:0]          id_call_target;

	cpu_host_regs u_host (
		.clk, .rst_n,
		.awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
		.bresp, .bvalid, .bready,
		.araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
		.start, .run, .imem_we, .imem_addr, .imem_wdata, .reg_rd_idx,
		.pc, .halted, .retired, .reg_rd_data
	);

	fetch_stage u_fetch (
		.clk, .rst_n, .start, .run, .jump_en, .jump_target,
		.imem_we, .imem_addr, .imem_wdata,
		.pc, .instr, .instr_valid
	);

	ifid_reg u_ifid (
		.clk, .rst_n, .flush,
		.pc_in       (pc),
		.instr, .instr_valid,
		.valid       (id_valid),
		.opcode      (id_opcode),
		.reg_rs      (id_rs),
		.reg_rt      (id_rt),
		.reg_rd      (id_rd),
		.arith_imm   (id_arith_imm),
		.load_imm    (id_load_imm),
		.call_target (id_call_target),
		.pc_out      ()
	);

	execute_stage u_exec (
		.clk, .rst_n, .start,
		.valid       (id_valid),
		.opcode      (id_opcode),
		.reg_rs      (id_rs),
		.reg_rt      (id_rt),
		.reg_rd      (id_rd),
		.arith_imm   (id_arith_imm),
		.load_imm    (id_load_imm),
		.call_target (id_call_target),
		.reg_rd_idx, .reg_rd_data,
		.jump_en, .jump_target, .flush, .halted, .retired
	);

endmodule

`default_nettype wire

// File: execute_stage.sv
// Execute stage with register file, ALU, writeback, jump and halt detection, retired counter
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module execute_stage (
	input  wire logic                 clk,
	input  wire logic                 rst_n,
	input  wire logic                 start,
	input  wire logic                 valid,
	input  wire isa_pkg::opcode_e     opcode,
	input  wire logic [3:0]           reg_rs,
	input  wire logic [3:0]           reg_rt,
	input  wire logic [3:0]           reg_rd,
	input  wire logic [3:0]           arith_imm,
	input  wire logic [7:0]           load_imm,
	input  wire logic [11:0]          call_target,
	input  wire logic [3:0]           reg_rd_idx,
	output logic [`CPU_XLEN-1:0]      reg_rd_data,
	output logic                      jump_en,
	output logic [`CPU_PC_W-1:0]      jump_target,
	output logic                      flush,
	output logic                      halted,
	output logic [`CPU_XLEN-1:0]      retired
);

	logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];
	logic [`CPU_XLEN-1:0] rs_val;
	logic [`CPU_XLEN-1:0] rt_val;
	logic [`CPU_XLEN-1:0] rd_val;
	logic [`CPU_XLEN-1:0] wb_val;
	logic                 wb_en;
	logic                 exec;		// instruction really executes
	logic                 halt_hit;

	assign exec = valid && !halted;	// anything behind HALT is dropped

	// Operand reads see the previous instruction's write
	assign rs_val = regs[reg_rs];
	assign rt_val = regs[reg_rt];
	assign rd_val = regs[reg_rd];

	// ALU
	always_comb begin
		wb_en  = exec;
		wb_val = '0;
		case (opcode)
			isa_pkg::OP_ADD:  wb_val = rs_val + rt_val;
			isa_pkg::OP_SUB:  wb_val = rs_val - rt_val;
			isa_pkg::OP_AND:  wb_val = rs_val & rt_val;
			isa_pkg::OP_OR:   wb_val = rs_val | rt_val;
			isa_pkg::OP_ADDI: wb_val = rd_val + {{(`CPU_XLEN-4){1'b0}}, arith_imm};
			isa_pkg::OP_LDI:  wb_val = {{(`CPU_XLEN-8){1'b0}}, load_imm};
			default:          wb_en  = 1'b0;	// JMP, HALT, NOPs
		endcase
	end

	// Registers keep their values across a restart
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `CPU_NREGS; i++)
				regs[i] <= '0;
		end else if (wb_en) begin
			regs[reg_rd] <= wb_val;
		end
	end

	assign reg_rd_data = regs[reg_rd_idx];	// host read-back

	// Control flow
	assign jump_en     = exec && (opcode == isa_pkg::OP_JMP);
	assign jump_target = call_target[`CPU_PC_W-1:0];	// modulo memory depth
	assign flush       = jump_en || start;				// restart drops the old word too
	assign halt_hit    = exec && (opcode == isa_pkg::OP_HALT);

	// Halt flag and retired count restart with start
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			halted  <= 1'b0;
			retired <= '0;
		end else if (start) begin
			halted  <= 1'b0;
			retired <= '0;
		end else if (halt_hit) begin
			halted <= 1'b1;		// HALT itself not counted
		end else if (exec) begin
			retired <= retired + 1'b1;
		end
	end

	// Only the word right behind HALT may still enter IF/ID
	a_no_issue_halted: assert property (@(posedge clk) disable iff (!rst_n)
		halted |=> !valid);

endmodule

`default_nettype wire

// File: fetch_stage.sv
// Fetch stage: PC, instruction memory with host load port, jump redirect, stop on halt
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module fetch_stage (
	input  wire logic                 clk,
	input  wire logic                 rst_n,
	input  wire logic                 start,
	input  wire logic                 run,
	input  wire logic                 jump_en,
	input  wire logic [`CPU_PC_W-1:0] jump_target,
	input  wire logic                 imem_we,
	input  wire logic [`CPU_PC_W-1:0] imem_addr,
	input  wire logic [`CPU_XLEN-1:0] imem_wdata,
	output logic [`CPU_PC_W-1:0]      pc,			// address of instr
	output isa_pkg::instr_u           instr,
	output logic                      instr_valid
);

	isa_pkg::instr_u      mem [`CPU_IMEM_DEPTH];
	logic [`CPU_PC_W-1:0] fetch_addr;
	logic                 fetch_go;
	logic                 fetched;	// instr holds a fresh word

	assign fetch_go = start || run;

	// Next address, restart beats redirect
	always_comb begin
		if (start)
			fetch_addr = '0;
		else if (jump_en)
			fetch_addr = jump_target;
		else
			fetch_addr = pc + 1'b1;	// wraps at depth
	end

	// Host load port
	always_ff @(posedge clk) begin
		if (imem_we)
			mem[imem_addr] <= imem_wdata;
	end

	// Registered read
	always_ff @(posedge clk) begin
		if (fetch_go)
			instr <= mem[fetch_addr];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc      <= '0;
			fetched <= 1'b0;
		end else begin
			if (fetch_go)
				pc <= fetch_addr;
			fetched <= fetch_go;
		end
	end

	// Word fetched under a halting HALT never reaches IF/ID
	assign instr_valid = fetched && run;

	// Program is only loaded with the core stopped
	a_no_load_while_run: assert property (@(posedge clk) disable iff (!rst_n)
		!(imem_we && run));

endmodule

`default_nettype wire

// File: hostmap_pkg.sv
// Host bus widths, register byte offsets, AXI response codes, control and status bits
`default_nettype none

package hostmap_pkg;

	parameter int ADDR_W = 12;	// AXI4-Lite address
	parameter int DATA_W = 32;	// AXI4-Lite data

	// Byte offsets on the slave port
	parameter logic [ADDR_W-1:0] CTRL_OFS    = 12'h000;
	parameter logic [ADDR_W-1:0] STATUS_OFS  = 12'h004;
	parameter logic [ADDR_W-1:0] PC_OFS      = 12'h008;
	parameter logic [ADDR_W-1:0] RETIRED_OFS = 12'h00C;
	parameter logic [ADDR_W-1:0] REG_BASE    = 12'h100;	// one word per register
	parameter logic [ADDR_W-1:0] IMEM_BASE   = 12'h400;	// one word per instruction

	parameter logic [1:0] RESP_OKAY   = 2'b00;
	parameter logic [1:0] RESP_SLVERR = 2'b10;

	parameter int CTRL_START_BIT   = 0;	// write 1 to restart from PC 0
	parameter int STAT_HALTED_BIT  = 0;
	parameter int STAT_RUNNING_BIT = 1;

endpackage

`default_nettype wire

// File: ifid_reg.sv
// IF/ID pipeline register: valid with flush, instruction split into its fields
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module ifid_reg (
	input  wire logic                 clk,
	input  wire logic                 rst_n,
	input  wire logic                 flush,
	input  wire logic [`CPU_PC_W-1:0] pc_in,
	input  wire isa_pkg::instr_u      instr,
	input  wire logic                 instr_valid,
	output logic                      valid,
	output isa_pkg::opcode_e          opcode,
	output logic [3:0]                reg_rs,
	output logic [3:0]                reg_rt,
	output logic [3:0]                reg_rd,
	output logic [3:0]                arith_imm,
	output logic [7:0]                load_imm,
	output logic [11:0]               call_target,
	output logic [`CPU_PC_W-1:0]      pc_out
);

	isa_pkg::instr_u ir;	// latched word

	// Flush squashes the word behind a taken jump
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			valid <= 1'b0;
		else if (flush)
			valid <= 1'b0;
		else
			valid <= instr_valid;
	end

	always_ff @(posedge clk) begin
		ir     <= instr;
		pc_out <= pc_in;
	end

	// Field split, all formats read the same bits
	assign opcode      = ir.r_fmt.opcode;
	assign reg_rd      = ir.r_fmt.rd;
	assign reg_rs      = ir.r_fmt.rs;
	assign reg_rt      = ir.r_fmt.rt;
	assign arith_imm   = ir.r_fmt.rt;		// ADDI reuses the rt slot
	assign load_imm    = ir.i_fmt.imm8;
	assign call_target = ir.j_fmt.target12;

endmodule

`default_nettype wire

// File: isa_pkg.sv
// ISA opcode encoding and the three views of the instruction word
`default_nettype none

package isa_pkg;

	// Top nibble of every instruction
	typedef enum logic [3:0] {
		OP_ADD  = 4'h0,
		OP_SUB  = 4'h1,
		OP_AND  = 4'h2,
		OP_OR   = 4'h3,
		OP_ADDI = 4'h4,
		OP_LDI  = 4'h5,
		OP_JMP  = 4'h6,
		OP_HALT = 4'h7	// 8..F run as NOP
	} opcode_e;

	// One word, decoded per opcode
	typedef union packed {
		struct packed {
			opcode_e    opcode;	// [15:12]
			logic [3:0] rd;		// [11:8]
			logic [3:0] rs;		// [7:4]
			logic [3:0] rt;		// [3:0], doubles as ADDI immediate
		} r_fmt;
		struct packed {
			opcode_e    opcode;
			logic [3:0] rd;
			logic [7:0] imm8;	// LDI value
		} i_fmt;
		struct packed {
			opcode_e     opcode;
			logic [11:0] target12;	// JMP target, wraps at memory depth
		} j_fmt;
	} instr_u;

endpackage

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build cpu_tb with Verilator, run it, judge by the pass line
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f verilog.f --top-module cpu_tb
out=$(./obj_dir/Vcpu_tb)
echo "$out"
if echo "$out" | grep -qxF '** PASS **'; then
	exit 0
fi
exit 1

// File: verilog.f
+incdir+.
isa_pkg.sv
hostmap_pkg.sv
cpu_host_regs.sv
fetch_stage.sv
ifid_reg.sv
execute_stage.sv
cpu_top.sv
cpu_tb.sv
